//--- rtl/fpmul_defs.svh
`ifndef FPMUL_DEFS_SVH
`define FPMUL_DEFS_SVH

// Binary64 field widths.
`define FP_EXP_W 11
`define FP_MAN_W 52

// Exponent limits.
`define FP_EXP_BIAS 1023
`define FP_EXP_MAX 2047

// Input strobe to output strobe, in cycles.
`define FPMUL_LATENCY 4

`endif

//--- rtl/fpmul_pkg.sv
package fpmul_pkg;

  // Opcode carried with each operation.
  typedef enum logic [0:0] {
    OP_MUL  = 1'b0,
    OP_NMUL = 1'b1  // Sign of the product inverted.
  } fp_op_e;

  // Operand class from decode.
  typedef enum logic [1:0] {
    CLASS_ZERO   = 2'd0,  // Also covers flushed subnormals.
    CLASS_NORMAL = 2'd1,
    CLASS_INF    = 2'd2,
    CLASS_NAN    = 2'd3
  } fp_class_e;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
  } fp_flags_t;

endpackage

//--- rtl/fpmul_if.sv
`timescale 1ns/1ps
`include "fpmul_defs.svh"

// Decode to execute.
interface unpacked_if;
  logic                 valid;
  fpmul_pkg::fp_op_e    op;
  logic                 sign_a;
  logic                 sign_b;
  logic [`FP_EXP_W-1:0] exp_a;
  logic [`FP_EXP_W-1:0] exp_b;
  logic [`FP_MAN_W:0]   man_a;  // Hidden one on top.
  logic [`FP_MAN_W:0]   man_b;
  fpmul_pkg::fp_class_e class_a;
  fpmul_pkg::fp_class_e class_b;

  modport src (
    output valid, op, sign_a, sign_b, exp_a, exp_b, man_a, man_b, class_a, class_b
  );

  modport dst (
    input valid, op, sign_a, sign_b, exp_a, exp_b, man_a, man_b, class_a, class_b
  );
endinterface

// Execute to result.
interface normalized_if;
  logic                        valid;
  fpmul_pkg::fp_op_e           op;
  logic                        sign;
  fpmul_pkg::fp_class_e        class_a;
  fpmul_pkg::fp_class_e        class_b;
  logic signed [`FP_EXP_W+1:0] exp_norm;  // Biased, may leave the field range.
  logic [`FP_MAN_W:0]          man_norm;
  logic                        round_up;

  modport src (
    output valid, op, sign, class_a, class_b, exp_norm, man_norm, round_up
  );

  modport dst (
    input valid, op, sign, class_a, class_b, exp_norm, man_norm, round_up
  );
endinterface

//--- rtl/mantissa_normalize.sv
`timescale 1ns/1ps
`include "fpmul_defs.svh"

module mantissa_normalize (
  input  logic [127:0]              mantissa_product,
  input  logic signed [`FP_EXP_W+1:0] exponent_init,
  output logic [`FP_MAN_W:0]        mantissa_normalized,
  output logic                      round,
  output logic signed [`FP_EXP_W+1:0] exponent_modified
);

  localparam int MAN_W = `FP_MAN_W;
  localparam logic [6:0] TARGET = 7'(MAN_W);         // Leading one lands here.
  localparam logic signed [`FP_EXP_W+1:0] POINT = 104;  // Binary point of the product.

  logic [6:0]   lead;
  logic         right_shift;
  logic [6:0]   shift_amt;
  logic [127:0] shifted;
  logic [127:0] drop_mask;
  logic         guard;
  logic         sticky;

  // Highest set bit wins.
  always_comb begin
    lead = '0;
    for (int i = 0; i < 128; i++) begin
      if (mantissa_product[i]) begin
        lead = 7'(i);
      end
    end
  end

  assign right_shift = (lead > TARGET);
  assign shift_amt   = right_shift ? (lead - TARGET) : (TARGET - lead);
  assign shifted     = right_shift ? (mantissa_product >> shift_amt)
                                   : (mantissa_product << shift_amt);

  assign mantissa_normalized = shifted[MAN_W:0];
  assign exponent_modified   = exponent_init + $signed({6'b0, lead}) - POINT;

  // Bits below the guard position.
  assign drop_mask = (128'd1 << (shift_amt - 7'd1)) - 128'd1;
  assign guard     = mantissa_product[shift_amt - 7'd1];
  assign sticky    = |(mantissa_product & drop_mask);

  // Ties go to even.
  assign round = right_shift & guard & (sticky | shifted[0]);

endmodule

//--- rtl/fpmul_decode.sv
`timescale 1ns/1ps
`include "fpmul_defs.svh"

module fpmul_decode (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  input  fpmul_pkg::fp_op_e op,
  input  logic [63:0]       operand_a,
  input  logic [63:0]       operand_b,
  unpacked_if.src           unp
);

  localparam int EXP_W = `FP_EXP_W;
  localparam int MAN_W = `FP_MAN_W;
  localparam logic [EXP_W-1:0] EXP_ALL_ONES = EXP_W'(`FP_EXP_MAX);

  logic [EXP_W-1:0]     exp_a;
  logic [EXP_W-1:0]     exp_b;
  logic [MAN_W-1:0]     frac_a;
  logic [MAN_W-1:0]     frac_b;
  fpmul_pkg::fp_class_e class_a;
  fpmul_pkg::fp_class_e class_b;

  function automatic fpmul_pkg::fp_class_e classify(input logic [EXP_W-1:0] exp_f,
                                                     input logic [MAN_W-1:0] frac);
    fpmul_pkg::fp_class_e cls;
    if (exp_f == '0) begin
      cls = fpmul_pkg::CLASS_ZERO;  // Subnormals flushed.
    end else if (exp_f == EXP_ALL_ONES) begin
      cls = (frac == '0) ? fpmul_pkg::CLASS_INF : fpmul_pkg::CLASS_NAN;
    end else begin
      cls = fpmul_pkg::CLASS_NORMAL;
    end
    return cls;
  endfunction

  assign exp_a  = operand_a[62 -: EXP_W];
  assign exp_b  = operand_b[62 -: EXP_W];
  assign frac_a = operand_a[MAN_W-1:0];
  assign frac_b = operand_b[MAN_W-1:0];

  assign class_a = classify(exp_a, frac_a);
  assign class_b = classify(exp_b, frac_b);

  always_ff @(posedge clk) begin
    if (reset) begin
      unp.valid <= 1'b0;
    end else begin
      unp.valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    unp.op      <= op;
    unp.sign_a  <= operand_a[63];
    unp.sign_b  <= operand_b[63];
    unp.exp_a   <= exp_a;
    unp.exp_b   <= exp_b;
    unp.class_a <= class_a;
    unp.class_b <= class_b;
    // Hidden one only for normal operands.
    unp.man_a   <= (class_a == fpmul_pkg::CLASS_NORMAL) ? {1'b1, frac_a} : '0;
    unp.man_b   <= (class_b == fpmul_pkg::CLASS_NORMAL) ? {1'b1, frac_b} : '0;
  end

endmodule

//--- rtl/fpmul_execute.sv
`timescale 1ns/1ps
`include "fpmul_defs.svh"

module fpmul_execute (
  input  logic      clk,
  input  logic      reset,
  unpacked_if.dst   unp,
  normalized_if.src nrm
);

  localparam int EXP_W  = `FP_EXP_W;
  localparam int MAN_W  = `FP_MAN_W;
  localparam int PROD_W = 2 * (MAN_W + 1);
  localparam logic signed [EXP_W+1:0] EXP_BIAS = (EXP_W+2)'(`FP_EXP_BIAS);

  logic [PROD_W-1:0]         man_prod;
  logic signed [EXP_W+1:0]   exp_sum;

  // Stage one.
  logic                      s1_valid;
  fpmul_pkg::fp_op_e         s1_op;
  logic                      s1_sign;
  fpmul_pkg::fp_class_e      s1_class_a;
  fpmul_pkg::fp_class_e      s1_class_b;
  logic [127:0]              s1_prod;
  logic signed [EXP_W+1:0]   s1_exp;

  // Normalizer outputs.
  logic [MAN_W:0]            norm_man;
  logic                      norm_round;
  logic signed [EXP_W+1:0]   norm_exp;

  assign man_prod = unp.man_a * unp.man_b;
  assign exp_sum  = $signed({2'b00, unp.exp_a}) + $signed({2'b00, unp.exp_b}) - EXP_BIAS;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      nrm.valid <= 1'b0;
    end else begin
      s1_valid <= unp.valid;
      nrm.valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_op      <= unp.op;
    s1_sign    <= unp.sign_a ^ unp.sign_b;
    s1_class_a <= unp.class_a;
    s1_class_b <= unp.class_b;
    s1_prod    <= {{(128-PROD_W){1'b0}}, man_prod};  // Zero-extended product.
    s1_exp     <= exp_sum;
  end

  mantissa_normalize u_normalize (
    .mantissa_product    (s1_prod),
    .exponent_init       (s1_exp),
    .mantissa_normalized (norm_man),
    .round               (norm_round),
    .exponent_modified   (norm_exp)
  );

  always_ff @(posedge clk) begin
    nrm.op       <= s1_op;
    nrm.sign     <= s1_sign;
    nrm.class_a  <= s1_class_a;
    nrm.class_b  <= s1_class_b;
    nrm.man_norm <= norm_man;
    nrm.exp_norm <= norm_exp;
    nrm.round_up <= norm_round;
  end

endmodule

//--- rtl/fpmul_result.sv
`timescale 1ns/1ps
`include "fpmul_defs.svh"

module fpmul_result (
  input  logic                 clk,
  input  logic                 reset,
  normalized_if.dst            nrm,
  output logic                 out_valid,
  output logic [63:0]          result,
  output fpmul_pkg::fp_flags_t flags
);

  localparam int EXP_W = `FP_EXP_W;
  localparam int MAN_W = `FP_MAN_W;
  localparam logic signed [EXP_W+1:0] EXP_MAX = (EXP_W+2)'(`FP_EXP_MAX);
  localparam logic [63:0] QNAN = 64'h7FF8_0000_0000_0000;

  logic [MAN_W+1:0]        man_round;
  logic                    carry;
  logic [MAN_W:0]          man_final;
  logic signed [EXP_W+1:0] exp_final;
  logic                    sign_out;
  logic                    any_nan;
  logic                    any_inf;
  logic                    any_zero;
  logic [63:0]             result_next;
  fpmul_pkg::fp_flags_t    flags_next;

  assign man_round = {1'b0, nrm.man_norm} + (MAN_W+2)'(nrm.round_up);
  assign carry     = man_round[MAN_W+1];  // Rounded up to 2^53.
  assign man_final = carry ? man_round[MAN_W+1:1] : man_round[MAN_W:0];
  assign exp_final = carry ? (nrm.exp_norm + (EXP_W+2)'(1)) : nrm.exp_norm;
  assign sign_out  = nrm.sign ^ (nrm.op == fpmul_pkg::OP_NMUL);

  assign any_nan  = (nrm.class_a == fpmul_pkg::CLASS_NAN) ||
                    (nrm.class_b == fpmul_pkg::CLASS_NAN);
  assign any_inf  = (nrm.class_a == fpmul_pkg::CLASS_INF) ||
                    (nrm.class_b == fpmul_pkg::CLASS_INF);
  assign any_zero = (nrm.class_a == fpmul_pkg::CLASS_ZERO) ||
                    (nrm.class_b == fpmul_pkg::CLASS_ZERO);

  // Special cases first, then range.
  always_comb begin
    flags_next = '0;
    if (any_nan) begin
      result_next = QNAN;
    end else if (any_inf && any_zero) begin
      result_next        = QNAN;
      flags_next.invalid = 1'b1;
    end else if (any_inf) begin
      result_next = {sign_out, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
    end else if (any_zero) begin
      result_next = {sign_out, 63'd0};
    end else if (exp_final >= EXP_MAX) begin
      result_next         = {sign_out, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
      flags_next.overflow = 1'b1;
    end else if (exp_final <= 0) begin
      result_next          = {sign_out, 63'd0};  // No subnormal results.
      flags_next.underflow = 1'b1;
    end else begin
      result_next = {sign_out, exp_final[EXP_W-1:0], man_final[MAN_W-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      flags     <= '0;
    end else begin
      out_valid <= nrm.valid;
      flags     <= nrm.valid ? flags_next : '0;  // Quiet between results.
    end
  end

  always_ff @(posedge clk) begin
    result <= result_next;
  end

endmodule

//--- rtl/fpmul_top.sv
`timescale 1ns/1ps

module fpmul_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  input  fpmul_pkg::fp_op_e    op,
  input  logic [63:0]          operand_a,
  input  logic [63:0]          operand_b,
  output logic                 out_valid,
  output logic [63:0]          result,
  output fpmul_pkg::fp_flags_t flags
);

  unpacked_if   unp_bus ();
  normalized_if nrm_bus ();

  // Unpack and classify.
  fpmul_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .op        (op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .unp       (unp_bus.src)
  );

  // Product and normalization, two stages.
  fpmul_execute u_execute (
    .clk   (clk),
    .reset (reset),
    .unp   (unp_bus.dst),
    .nrm   (nrm_bus.src)
  );

  // Rounding, specials and packing.
  fpmul_result u_result (
    .clk       (clk),
    .reset     (reset),
    .nrm       (nrm_bus.dst),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

endmodule

//--- test/fpmul_chk.sv
`timescale 1ns/1ps
`include "fpmul_defs.svh"

module fpmul_chk (
  input logic                 clk,
  input logic                 reset,
  input logic                 in_valid,
  input logic                 out_valid,
  input logic [63:0]          result,
  input fpmul_pkg::fp_flags_t flags
);

  localparam logic [63:0] QNAN = 64'h7FF8_0000_0000_0000;

  a_latency: assert property (@(posedge clk) disable iff (reset)
    out_valid == $past(in_valid, `FPMUL_LATENCY))
    else $error("out_valid does not follow in_valid by the pipeline latency");

  a_flags_quiet: assert property (@(posedge clk) disable iff (reset)
    !out_valid |-> (flags == 3'b000))
    else $error("flags set while out_valid is low");

  // Invalid only comes from infinity times zero.
  a_invalid_nan: assert property (@(posedge clk) disable iff (reset)
    (out_valid && flags.invalid) |-> (result == QNAN))
    else $error("invalid flag without the canonical quiet NaN");

  a_range_excl: assert property (@(posedge clk) disable iff (reset)
    !(flags.overflow && flags.underflow))
    else $error("overflow and underflow set together");

endmodule

bind fpmul_top fpmul_chk u_chk (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .result    (result),
  .flags     (flags)
);

//--- test/fpmul_tb.sv
`timescale 1ns/1ps
`include "fpmul_defs.svh"

module fpmul_tb;

  localparam int N_DIRECTED  = 18;
  localparam int N_RANDOM    = 200;
  localparam int N_ENTRIES   = N_DIRECTED + N_RANDOM;
  localparam int CYCLE_LIMIT = 16 + N_ENTRIES + `FPMUL_LATENCY + 20;
  localparam logic [63:0] QNAN = 64'h7FF8_0000_0000_0000;
  localparam fpmul_pkg::fp_flags_t NO_FLAGS  = 3'b000;
  localparam fpmul_pkg::fp_flags_t INVALID   = 3'b100;
  localparam fpmul_pkg::fp_flags_t OVERFLOW  = 3'b010;
  localparam fpmul_pkg::fp_flags_t UNDERFLOW = 3'b001;

  logic                 clk;
  logic                 reset;
  logic                 in_valid;
  fpmul_pkg::fp_op_e    op;
  logic [63:0]          operand_a;
  logic [63:0]          operand_b;
  logic                 out_valid;
  logic [63:0]          result;
  fpmul_pkg::fp_flags_t flags;

  integer seed;
  int     cycle = 0;
  int     checked = 0;
  int     n_built = 0;

  // Stimulus and expected values, one row per operation.
  fpmul_pkg::fp_op_e    tbl_op    [N_ENTRIES];
  logic [63:0]          tbl_a     [N_ENTRIES];
  logic [63:0]          tbl_b     [N_ENTRIES];
  logic [63:0]          tbl_res   [N_ENTRIES];
  fpmul_pkg::fp_flags_t tbl_flags [N_ENTRIES];

  logic [63:0]          exp_result_q [$];
  fpmul_pkg::fp_flags_t exp_flags_q  [$];
  int                   exp_edge_q   [$];  // Last edge before the input is taken.

  fpmul_top DUT (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .op        (op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string why);
    $display("Testbench failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_result(input int idx, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error: time %0t: entry %0d result %h, expected %h", $time, idx, got, exp);
      abort_run("result mismatch");
    end
  endtask

  task automatic check_flags(input int idx, input fpmul_pkg::fp_flags_t got,
                             input fpmul_pkg::fp_flags_t exp);
    if (got !== exp) begin
      $display("error: time %0t: entry %0d flags %b, expected %b", $time, idx, got, exp);
      abort_run("flags mismatch");
    end
  endtask

  task automatic check_latency(input int idx, input int got, input int exp);
    if (got != exp) begin
      $display("error: time %0t: entry %0d came out at cycle %0d, expected %0d",
               $time, idx, got, exp);
      abort_run("latency mismatch");
    end
  endtask

  task automatic add_entry(input fpmul_pkg::fp_op_e e_op, input logic [63:0] a,
                           input logic [63:0] b, input logic [63:0] res,
                           input fpmul_pkg::fp_flags_t fl);
    tbl_op[n_built]    = e_op;
    tbl_a[n_built]     = a;
    tbl_b[n_built]     = b;
    tbl_res[n_built]   = res;
    tbl_flags[n_built] = fl;
    n_built++;
  endtask

  // Normal operand, exponent kept in 700..1300.
  function automatic logic [63:0] random_operand();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [10:0] e;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    e  = 11'(700 + (r2[15:0] % 601));
    return {r2[31], e, r1[19:0], r0};
  endfunction

  task automatic add_random_entry();
    logic [63:0]       a;
    logic [63:0]       b;
    logic [63:0]       res;
    logic [31:0]       r;
    fpmul_pkg::fp_op_e e_op;
    a    = random_operand();
    b    = random_operand();
    r    = $random(seed);
    e_op = r[0] ? fpmul_pkg::OP_NMUL : fpmul_pkg::OP_MUL;
    res  = $realtobits($bitstoreal(a) * $bitstoreal(b));  // Host multiply rounds to even.
    if (e_op == fpmul_pkg::OP_NMUL) begin
      res[63] = ~res[63];
    end
    add_entry(e_op, a, b, res, NO_FLAGS);
  endtask

  task automatic build_table();
    add_entry(fpmul_pkg::OP_MUL,  64'h3FF8000000000000, 64'h4000000000000000,
              64'h4008000000000000, NO_FLAGS);
    add_entry(fpmul_pkg::OP_MUL,  64'h4008000000000000, 64'hBFE0000000000000,
              64'hBFF8000000000000, NO_FLAGS);
    add_entry(fpmul_pkg::OP_NMUL, 64'h3FF8000000000000, 64'h4000000000000000,
              64'hC008000000000000, NO_FLAGS);
    add_entry(fpmul_pkg::OP_NMUL, 64'h4008000000000000, 64'hBFE0000000000000,
              64'h3FF8000000000000, NO_FLAGS);
    // Exact ties, one rounds up and one stays even.
    add_entry(fpmul_pkg::OP_MUL,  64'h3FF0000000000001, 64'h3FF8000000000000,
              64'h3FF8000000000002, NO_FLAGS);
    add_entry(fpmul_pkg::OP_MUL,  64'h3FF0000000000003, 64'h3FF8000000000000,
              64'h3FF8000000000004, NO_FLAGS);
    // Tie at 2 - 2^-53, carries into the exponent.
    add_entry(fpmul_pkg::OP_MUL,  64'h3FF8000000000000, 64'h3FF5555555555555,
              64'h4000000000000000, NO_FLAGS);
    add_entry(fpmul_pkg::OP_MUL,  64'h3FFFFFFFFFFFFFFF, 64'h3FFFFFFFFFFFFFFF,
              64'h400FFFFFFFFFFFFE, NO_FLAGS);
    add_entry(fpmul_pkg::OP_MUL,  64'h7FF0000000000001, 64'h3FF0000000000000, QNAN, NO_FLAGS);
    add_entry(fpmul_pkg::OP_MUL,  64'h7FF8000000000000, 64'h0000000000000000, QNAN, NO_FLAGS);
    add_entry(fpmul_pkg::OP_MUL,  64'h7FF0000000000000, 64'h0000000000000000, QNAN, INVALID);
    add_entry(fpmul_pkg::OP_MUL,  64'hFFF0000000000000, 64'h4000000000000000,
              64'hFFF0000000000000, NO_FLAGS);
    add_entry(fpmul_pkg::OP_NMUL, 64'h7FF0000000000000, 64'h4000000000000000,
              64'hFFF0000000000000, NO_FLAGS);
    add_entry(fpmul_pkg::OP_MUL,  64'h8000000000000000, 64'h4008000000000000,
              64'h8000000000000000, NO_FLAGS);
    add_entry(fpmul_pkg::OP_MUL,  64'h0000000000000001, 64'hC000000000000000,
              64'h8000000000000000, NO_FLAGS);  // Subnormal input.
    add_entry(fpmul_pkg::OP_MUL,  64'h7FE0000000000000, 64'h4000000000000000,
              64'h7FF0000000000000, OVERFLOW);
    add_entry(fpmul_pkg::OP_MUL,  64'h8010000000000000, 64'h0010000000000000,
              64'h8000000000000000, UNDERFLOW);
    add_entry(fpmul_pkg::OP_MUL,  64'h0010000000000000, 64'h3FE0000000000000,
              64'h0000000000000000, UNDERFLOW);  // Exponent lands on 0.
    for (int i = 0; i < N_RANDOM; i++) begin
      add_random_entry();
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run("timeout");
    end
  end

  // Outputs settle after the rising edge.
  always @(negedge clk) begin
    if (out_valid === 1'b1) begin
      if (exp_result_q.size() == 0) begin
        $display("out_valid went high at cycle %0d with no operation in flight", cycle);
        abort_run("unexpected result");
      end else begin
        check_result(checked, result, exp_result_q.pop_front());
        check_flags(checked, flags, exp_flags_q.pop_front());
        check_latency(checked, cycle, exp_edge_q.pop_front() + `FPMUL_LATENCY);
        checked <= checked + 1;
      end
    end
  end

  initial begin
    seed      = 32'h3c7d;
    clk       = 1'b0;
    reset     = 1'b1;
    in_valid  = 1'b0;
    op        = fpmul_pkg::OP_MUL;
    operand_a = '0;
    operand_b = '0;
    build_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);  // Idle gap before the first strobe.
    for (int i = 0; i < N_ENTRIES; i++) begin
      @(negedge clk);
      in_valid  = 1'b1;
      op        = tbl_op[i];
      operand_a = tbl_a[i];
      operand_b = tbl_b[i];
      exp_result_q.push_back(tbl_res[i]);
      exp_flags_q.push_back(tbl_flags[i]);
      exp_edge_q.push_back(cycle);
    end
    @(negedge clk);
    in_valid  = 1'b0;
    operand_a = '0;
    operand_b = '0;
    repeat (`FPMUL_LATENCY + 6) @(negedge clk);  // Drain, then the pipeline must stay quiet.
    if (exp_result_q.size() != 0) begin
      $display("%0d results never came out", exp_result_q.size());
      abort_run("missing results");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- project.f
+incdir+rtl
rtl/fpmul_pkg.sv
rtl/fpmul_if.sv
rtl/mantissa_normalize.sv
rtl/fpmul_decode.sv
rtl/fpmul_execute.sv
rtl/fpmul_result.sv
rtl/fpmul_top.sv
test/fpmul_chk.sv
test/fpmul_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the fpmul testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module fpmul_tb \
  -f project.f \
  -o fpmul_sim

./obj_dir/fpmul_sim
